// ==== Bender.yml ====
package:
  name: hpam_mul

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hpam_mul_pkg.sv
      - verilog/hpam_pp_array.sv
      - verilog/hpam_wallace_tree.sv
      - verilog/hpam_apb_regs.sv
      - verilog/hpam_mul_top.sv
  - target: test
    files:
      - tb/hpam_tb_clk.sv
      - tb/hpam_mul_tb.sv

// ==== hpam_mul.f ====
+incdir+verilog
verilog/hpam_mul_pkg.sv
verilog/hpam_pp_array.sv
verilog/hpam_wallace_tree.sv
verilog/hpam_apb_regs.sv
verilog/hpam_mul_top.sv
tb/hpam_tb_clk.sv
tb/hpam_mul_tb.sv

// ==== tb/hpam_mul_tb.sv ====
// Drives hpam_mul_top over APB only; expects zero-wait slave, stops at first mismatch
`timescale 1ns/1ps
`include "hpam_mul_macros.svh"

module hpam_mul_tb;

    // Inputs move this long after each rising edge
    localparam int DRIVE_DLY  = 5;
    localparam int WAIT_LIMIT = 20;
    localparam int N_FIXED    = 9;
    localparam int N_RAND     = 40;
    localparam int N_ROWS     = N_FIXED + N_RAND;

    // Access kinds of a table row
    localparam int KIND_RW        = 0;
    localparam int KIND_BAD_ADDR  = 1;
    localparam int KIND_WR_RESULT = 2;

    localparam hpam_mul_pkg::apb_addr_t ADDR_OPS  = `HPAM_ADDR_OPERANDS;
    localparam hpam_mul_pkg::apb_addr_t ADDR_RES  = `HPAM_ADDR_RESULT;
    localparam hpam_mul_pkg::apb_addr_t ADDR_BAD  = 4'h8;
    localparam hpam_mul_pkg::apb_addr_t ADDR_BAD2 = 4'hc;

    logic                    clk;
    logic                    arst_n;
    hpam_mul_pkg::apb_addr_t paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    hpam_mul_pkg::apb_data_t pwdata;
    hpam_mul_pkg::apb_data_t prdata;
    logic                    pready;
    logic                    pslverr;

    // Operands last accepted by the DUT, zero out of reset
    logic [7:0] last_a;
    logic [7:0] last_b;

    // Stimulus table, expected RESULT per row
    logic [7:0]  row_a    [N_ROWS];
    logic [7:0]  row_b    [N_ROWS];
    int          row_kind [N_ROWS];
    logic [15:0] row_exp  [N_ROWS];

    hpam_tb_clk u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    hpam_mul_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    // Sum of a[i]&b[j] at weight 2^(i+j), light columns left out
    function automatic logic [15:0] truncated_product(input logic [7:0] a, input logic [7:0] b);
        int sum;
        sum = 0;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                if (i + j >= `HPAM_TRUNC_COLS && a[i] && b[j]) begin
                    sum += 1 << (i + j);
                end
            end
        end
        return sum[15:0];
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, exp, act);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_not_above(input string name, input int limit, input logic [31:0] act);
        assert (act <= limit) else begin
            $display("CHECK FAILED at %0t ns: %s expected at most %0d, got %0d",
                     $time, name, limit, act);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on timeout");
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////////////////////////

    // One transfer, setup then access, response sampled mid-cycle
    task automatic apb_transfer(input logic wr, input hpam_mul_pkg::apb_addr_t addr,
                                input hpam_mul_pkg::apb_data_t wdata,
                                output hpam_mul_pkg::apb_data_t rdata, output logic err);
        int waited;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wr ? wdata : '0;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("pready in the APB access phase");
            end
            waited++;
            @(negedge clk);
        end
        // Zero-wait slave, done in the first access cycle
        check_equal("pready wait cycles", 32'd0, waited);
        rdata = prdata;
        err   = pslverr;
        // Access ends on this edge
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input hpam_mul_pkg::apb_addr_t addr,
                             input hpam_mul_pkg::apb_data_t wdata, output logic err);
        hpam_mul_pkg::apb_data_t unused;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input hpam_mul_pkg::apb_addr_t addr,
                            output hpam_mul_pkg::apb_data_t rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table
    //////////////////////////////////////////////////////////////////////

    task automatic set_row(input int r, input logic [7:0] a, input logic [7:0] b,
                           input int kind, input logic [15:0] exp);
        row_a[r]    = a;
        row_b[r]    = b;
        row_kind[r] = kind;
        row_exp[r]  = exp;
    endtask

    task automatic build_table();
        logic [7:0] a;
        logic [7:0] b;
        set_row(0, 8'd0, 8'd255, KIND_RW, 16'd0);
        // 65025 less 49 from columns 0 to 3
        set_row(1, 8'd255, 8'd255, KIND_RW, 16'd64976);
        set_row(2, 8'd1, 8'd1, KIND_RW, 16'd0);
        // Only term sits in column 2
        set_row(3, 8'd4, 8'd1, KIND_RW, 16'd0);
        set_row(4, 8'd3, 8'd3, KIND_RW, 16'd0);
        set_row(5, 8'd16, 8'd1, KIND_RW, 16'd16);
        set_row(6, 8'd15, 8'd15, KIND_RW, 16'd176);
        // Error rows, exp unused there
        set_row(7, 8'ha5, 8'h3c, KIND_BAD_ADDR, 16'd0);
        set_row(8, 8'h5a, 8'hc3, KIND_WR_RESULT, 16'd0);
        for (int r = N_FIXED; r < N_ROWS; r++) begin
            a = 8'($urandom);
            b = 8'($urandom);
            set_row(r, a, b, KIND_RW, truncated_product(a, b));
        end
    endtask

    task automatic run_row(input int r);
        hpam_mul_pkg::apb_data_t wdata;
        hpam_mul_pkg::apb_data_t ops_exp;
        hpam_mul_pkg::apb_data_t rdata;
        logic                    err;
        int                      exact;
        // Upper write bits set, they must read back as zero
        wdata   = {16'hffff, row_b[r], row_a[r]};
        ops_exp = {16'h0, row_b[r], row_a[r]};
        exact   = int'(row_a[r]) * int'(row_b[r]);
        if (row_kind[r] == KIND_RW) begin
            apb_write(ADDR_OPS, wdata, err);
            check_equal("pslverr on OPERANDS write", 32'd0, err);
            last_a = row_a[r];
            last_b = row_b[r];
            apb_read(ADDR_OPS, rdata, err);
            check_equal("prdata OPERANDS", ops_exp, rdata);
            check_equal("pslverr on OPERANDS read", 32'd0, err);
            apb_read(ADDR_RES, rdata, err);
            check_equal("pslverr on RESULT read", 32'd0, err);
            check_equal("RESULT[3:0]", 32'd0, rdata[3:0]);
            check_not_above("RESULT vs exact a*b", exact, rdata);
            check_equal("prdata RESULT", row_exp[r], rdata);
        end else begin
            if (row_kind[r] == KIND_BAD_ADDR) begin
                apb_write(ADDR_BAD, wdata, err);
                check_equal("pslverr on unmapped write", 32'd1, err);
                apb_read(ADDR_BAD2, rdata, err);
                check_equal("pslverr on unmapped read", 32'd1, err);
            end else begin
                apb_write(ADDR_RES, wdata, err);
                check_equal("pslverr on RESULT write", 32'd1, err);
            end
            // Neither register may move
            apb_read(ADDR_OPS, rdata, err);
            check_equal("prdata OPERANDS after error", {16'h0, last_b, last_a}, rdata);
            apb_read(ADDR_RES, rdata, err);
            check_equal("prdata RESULT after error", truncated_product(last_a, last_b),
                        rdata);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        hpam_mul_pkg::apb_data_t rdata;
        logic                    err;
        int                      waited;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        last_a  = 8'd0;
        last_b  = 8'd0;
        void'($urandom(52238));
        build_table();

        waited = 0;
        while (arst_n !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("reset release");
            end
            waited++;
            @(posedge clk);
        end

        // Registers come out of reset at zero
        apb_read(ADDR_RES, rdata, err);
        check_equal("prdata RESULT after reset", 32'd0, rdata);
        check_equal("pslverr after reset", 32'd0, err);
        apb_read(ADDR_OPS, rdata, err);
        check_equal("prdata OPERANDS after reset", 32'd0, rdata);
        check_equal("pslverr after reset", 32'd0, err);

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb/hpam_tb_clk.sv ====
// Free-running 100 ns clock; arst_n is held low for the first 3 rising edges only
`timescale 1ns/1ps

module hpam_tb_clk (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 50;

    // Clock starts low, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after the third edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

// ==== verilog/hpam_apb_regs.sv ====
// Zero-wait APB slave; RESULT reflects an operand write one clk later, setup phase covers it
`timescale 1ns/1ps
`include "hpam_mul_macros.svh"

module hpam_apb_regs (
    input  logic                    clk,
    input  logic                    arst_n,
    input  hpam_mul_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  hpam_mul_pkg::apb_data_t pwdata,
    output hpam_mul_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  hpam_mul_pkg::product_t  product,
    output hpam_mul_pkg::operand_t  op_a,
    output hpam_mul_pkg::operand_t  op_b
);

    localparam int OP_W   = `HPAM_OP_W;
    localparam int PROD_W = `HPAM_PROD_W;
    localparam int DW     = `HPAM_APB_DW;

    logic                   setup;
    logic                   access;
    logic                   hit_ops;
    logic                   hit_res;
    logic                   bad_addr;
    logic                   rd_ops_q;
    logic                   rd_res_q;
    hpam_mul_pkg::product_t result_q;

    //////////////////////////////////////////////////////////////////
    // Phase and address decode
    //////////////////////////////////////////////////////////////////

    assign setup   = psel & ~penable;
    assign access  = psel & penable;
    assign hit_ops = (paddr == hpam_mul_pkg::apb_addr_t'(`HPAM_ADDR_OPERANDS));
    assign hit_res = (paddr == hpam_mul_pkg::apb_addr_t'(`HPAM_ADDR_RESULT));

    // Unmapped, or write to read-only RESULT
    assign bad_addr = ~(hit_ops | hit_res) | (pwrite & hit_res);

    // No wait states
    assign pready = 1'b1;

    //////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_a     <= '0;
            op_b     <= '0;
            result_q <= '0;
            rd_ops_q <= 1'b0;
            rd_res_q <= 1'b0;
            pslverr  <= 1'b0;
        end else begin
            // Operands load at the end of the access phase
            if (access && pwrite && hit_ops) begin
                op_a <= pwdata[OP_W-1:0];
                op_b <= pwdata[2*OP_W-1:OP_W];
            end
            // Tracks the combinational tree every edge
            result_q <= product;
            // Read select and error captured in setup
            // Held for exactly the access cycle
            rd_ops_q <= setup & ~pwrite & hit_ops;
            rd_res_q <= setup & ~pwrite & hit_res;
            pslverr  <= setup & bad_addr;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Read data
    //////////////////////////////////////////////////////////////////

    // Registered select over registered data
    // RESULT already holds the new product by the access cycle
    always_comb begin
        prdata = '0;
        if (rd_ops_q) begin
            prdata = {{(DW - 2*OP_W){1'b0}}, op_b, op_a};
        end else if (rd_res_q) begin
            prdata = {{(DW - PROD_W){1'b0}}, result_q};
        end
    end

endmodule

// ==== verilog/hpam_mul_macros.svh ====
// Fixed 8x8 unsigned build; changing widths also moves the register map and APB data packing
`ifndef HPAM_MUL_MACROS_SVH
`define HPAM_MUL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Operand width
`define HPAM_OP_W 8
// Full product width, 2 x operand
`define HPAM_PROD_W 16
// Low columns dropped by the approximation
`define HPAM_TRUNC_COLS 4

//////////////////////////////////////////////////////////////////////
// APB register map
//////////////////////////////////////////////////////////////////////

`define HPAM_APB_AW 4
`define HPAM_APB_DW 32
`define HPAM_ADDR_OPERANDS 0
`define HPAM_ADDR_RESULT 4

`endif

// ==== verilog/hpam_mul_pkg.sv ====
// Unsigned types only; sizes follow the macro header and no signed variant exists
package hpam_mul_pkg;

`include "hpam_mul_macros.svh"

    //////////////////////////////////////////////////////////////////
    // Arithmetic types
    //////////////////////////////////////////////////////////////////

    // One multiplier operand
    typedef logic [`HPAM_OP_W-1:0] operand_t;

    // Approximate product, low columns always zero
    typedef logic [`HPAM_PROD_W-1:0] product_t;

    // Partial products
    // Outer index is the a bit, inner index the b bit
    // Entry [i][j] sits in column i+j
    typedef logic [`HPAM_OP_W-1:0][`HPAM_OP_W-1:0] pp_matrix_t;

    //////////////////////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////////////////////

    // APB byte address
    typedef logic [`HPAM_APB_AW-1:0] apb_addr_t;

    // APB read and write data
    typedef logic [`HPAM_APB_DW-1:0] apb_data_t;

endpackage

// ==== verilog/hpam_mul_top.sv ====
// APB-mapped HPAM multiplier; result is approximate, low 4 bits read as zero
`timescale 1ns/1ps

module hpam_mul_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  hpam_mul_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  hpam_mul_pkg::apb_data_t pwdata,
    output hpam_mul_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr
);

    hpam_mul_pkg::operand_t   op_a;
    hpam_mul_pkg::operand_t   op_b;
    hpam_mul_pkg::pp_matrix_t pp;
    hpam_mul_pkg::product_t   product;

    //////////////////////////////////////////////////////////////////
    // Bus block, owns operand and result registers
    //////////////////////////////////////////////////////////////////

    hpam_apb_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .product (product),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    // Combinational arithmetic path
    hpam_pp_array u_pp (
        .a  (op_a),
        .b  (op_b),
        .pp (pp)
    );

    hpam_wallace_tree u_tree (
        .pp      (pp),
        .product (product)
    );

endmodule

// ==== verilog/hpam_pp_array.sv ====
// Unsigned AND array; entries below column HPAM_TRUNC_COLS are tied to zero, never computed
`timescale 1ns/1ps
`include "hpam_mul_macros.svh"

module hpam_pp_array (
    input  hpam_mul_pkg::operand_t   a,
    input  hpam_mul_pkg::operand_t   b,
    output hpam_mul_pkg::pp_matrix_t pp
);

    localparam int OP_W  = `HPAM_OP_W;
    localparam int TRUNC = `HPAM_TRUNC_COLS;

    //////////////////////////////////////////////////////////////////
    // Partial product generation
    //////////////////////////////////////////////////////////////////

    // Row i is a[i] gating all of b
    for (genvar i = 0; i < OP_W; i++) begin : g_row
        for (genvar j = 0; j < OP_W; j++) begin : g_col
            if (i + j < TRUNC) begin : g_drop
                // HPAM truncation
                // Column too light, no gate and no carry from here
                assign pp[i][j] = 1'b0;
            end else begin : g_keep
                // Kept term, weight 2^(i+j)
                assign pp[i][j] = a[i] & b[j];
            end
        end
    end

    // Column heights after truncation, for reference
    //   col 4..7   : 5, 6, 7, 8
    //   col 8..14  : 7 down to 1
    // Columns 0..3 hold nothing

endmodule

// ==== verilog/hpam_wallace_tree.sv ====
// Needs the truncated pp matrix; bits below HPAM_TRUNC_COLS are zero and bit-15 carry-out is dropped
`timescale 1ns/1ps
`include "hpam_mul_macros.svh"

module hpam_wallace_tree (
    input  hpam_mul_pkg::pp_matrix_t pp,
    output hpam_mul_pkg::product_t   product
);

    localparam int OP_W   = `HPAM_OP_W;
    localparam int PROD_W = `HPAM_PROD_W;
    localparam int TRUNC  = `HPAM_TRUNC_COLS;

    // 3:2 counters in a column of height h
    function automatic int fa_count(input int h);
        return (h > 2) ? h / 3 : 0;
    endfunction

    // One 2:2 counter when two bits remain
    function automatic int ha_count(input int h);
        return (h > 2 && h % 3 == 2) ? 1 : 0;
    endfunction

    // Bits held by column col after the given number of layers
    function automatic int tree_height(input int layer, input int col);
        int h   [PROD_W];
        int nxt [PROD_W];
        for (int c = 0; c < PROD_W; c++) begin
            h[c] = 0;
            for (int i = 0; i < OP_W; i++) begin
                if (c >= TRUNC && c - i >= 0 && c - i < OP_W) begin
                    h[c]++;
                end
            end
        end
        for (int l = 0; l < layer; l++) begin
            for (int c = 0; c < PROD_W; c++) begin
                // Sums and leftovers stay, carries come in from the right
                nxt[c] = h[c] - 2 * fa_count(h[c]) - ha_count(h[c]);
                if (c > 0) begin
                    nxt[c] += fa_count(h[c-1]) + ha_count(h[c-1]);
                end
            end
            h = nxt;
        end
        return (col >= 0 && col < PROD_W) ? h[col] : 0;
    endfunction

    // Layers until every column is down to two rows
    function automatic int tree_layers();
        int hmax;
        for (int l = 0; l < 2 * OP_W; l++) begin
            hmax = 0;
            for (int c = 0; c < PROD_W; c++) begin
                if (tree_height(l, c) > hmax) begin
                    hmax = tree_height(l, c);
                end
            end
            if (hmax <= 2) begin
                return l;
            end
        end
        return 2 * OP_W;
    endfunction

    localparam int NL   = tree_layers();
    // Tallest column is the centre one at layer 0
    localparam int HMAX = OP_W;

    // Column contents per layer, unused slots held at zero
    logic [HMAX-1:0] bits [NL+1][PROD_W];
    logic [PROD_W-1:TRUNC] rc;

    //////////////////////////////////////////////////////////////////
    // Layer 0, pack each kept column from the pp matrix
    //////////////////////////////////////////////////////////////////

    for (genvar c = 0; c < PROD_W; c++) begin : g_l0
        localparam int H0 = tree_height(0, c);
        // Lowest a index that lands in this column
        localparam int LO = (c > OP_W - 1) ? c - OP_W + 1 : 0;
        for (genvar k = 0; k < HMAX; k++) begin : g_bit
            if (k < H0) begin : g_pp
                assign bits[0][c][k] = pp[LO+k][c-LO-k];
            end else begin : g_nil
                assign bits[0][c][k] = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Carry-save layers
    //////////////////////////////////////////////////////////////////

    // Slot order in the next layer
    //   FA sums, HA sum, leftovers, then carries from column c-1
    for (genvar l = 0; l < NL; l++) begin : g_layer
        for (genvar c = 0; c < PROD_W; c++) begin : g_col
            localparam int H    = tree_height(l, c);
            localparam int NFA  = fa_count(H);
            localparam int NHA  = ha_count(H);
            localparam int OWN  = H - 2 * NFA - NHA;
            localparam int HP   = tree_height(l, c - 1);
            localparam int NFAP = fa_count(HP);
            localparam int NHAP = ha_count(HP);
            for (genvar k = 0; k < HMAX; k++) begin : g_slot
                if (k < NFA) begin : g_fa_sum
                    assign bits[l+1][c][k] = ^bits[l][c][3*k +: 3];
                end else if (k < NFA + NHA) begin : g_ha_sum
                    assign bits[l+1][c][k] = bits[l][c][3*NFA] ^ bits[l][c][3*NFA+1];
                end else if (k < OWN) begin : g_pass
                    // Single leftover, or column already short enough
                    assign bits[l+1][c][k] = bits[l][c][k + 2*NFA + NHA];
                end else if (k < OWN + NFAP) begin : g_fa_cy
                    localparam int M = 3 * (k - OWN);
                    // Majority of the FA triple one column right
                    assign bits[l+1][c][k] = (bits[l][c-1][M] & bits[l][c-1][M+1])
                                           | (bits[l][c-1][M] & bits[l][c-1][M+2])
                                           | (bits[l][c-1][M+1] & bits[l][c-1][M+2]);
                end else if (k < OWN + NFAP + NHAP) begin : g_ha_cy
                    assign bits[l+1][c][k] = bits[l][c-1][3*NFAP] & bits[l][c-1][3*NFAP+1];
                end else begin : g_nil
                    assign bits[l+1][c][k] = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Final ripple chain over the two remaining rows
    //////////////////////////////////////////////////////////////////

    // Start node, no carry from the dropped columns
    assign rc[TRUNC] = 1'b0;

    for (genvar c = 0; c < PROD_W; c++) begin : g_rca
        if (c < TRUNC) begin : g_low
            assign product[c] = 1'b0;
        end else begin : g_node
            logic x;
            logic y;
            assign x = bits[NL][c][0];
            assign y = bits[NL][c][1];
            assign product[c] = x ^ y ^ rc[c];
            // Carry out of bit 15 is always zero
            if (c < PROD_W - 1) begin : g_cy
                assign rc[c+1] = (x & y) | (rc[c] & (x ^ y));
            end
        end
    end

endmodule
